/* vlog.f */
common/pulse_tx_pkg.sv
sequencer/symbol_decoder.sv
sequencer/symbol_timer.sv
sequencer/pulse_sequencer.sv
verilog/symbol_memory.sv
verilog/pulse_tx_regs.sv
verilog/pulse_tx_top.sv
test/pulse_tx_asserts.sv
test/pulse_tx_tb.sv

/* test/pulse_tx_tb.sv */
/*
  Directed testbench for the pulse transmitter.
  Expected waveforms come from a software model of the symbol rules.
  The model only reads program word 0, so tests keep indices below 32.
  Waveform runs are sampled on uo_out[4] while uo_out[2] is high.
*/
module pulse_tx_tb
    import pulse_tx_pkg::*;
();

    localparam int         TIMEOUT    = 5000;
    localparam logic [5:0] CTRL_ADDR  = 6'h00;
    localparam logic [5:0] PROG_ADDR  = 6'h04;
    localparam logic [5:0] DUR_ADDR   = 6'h08;
    localparam logic [5:0] PRE_ADDR   = 6'h0C;
    localparam logic [5:0] WORD0_ADDR = 6'h20;
    localparam logic [1:0] WR32       = 2'b10;
    localparam logic [1:0] WR8        = 2'b00;

    logic       clk = 1'b0;
    logic       rst_n;
    logic [5:0] address;
    bus_word_t  data_in;
    logic [1:0] data_write_n;
    logic [1:0] data_read_n;
    bus_word_t  data_out;
    logic       data_ready;
    logic [7:0] uo_out;
    logic       user_interrupt;

    int    errors = 0;
    int    timeouts = 0;
    string test_name = "reset";
    // Expected and observed (level, cycles) runs
    logic  exp_lvl[$];
    int    exp_len[$];
    int    exp_loops;
    logic  obs_lvl[$];
    int    obs_len[$];
    logic  run_lvl;
    int    run_len = 0;

    pulse_tx_top #(
        .LOOP_COUNT_WIDTH (LOOP_COUNT_WIDTH)
    ) u_pulse_tx_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .address        (address),
        .data_in        (data_in),
        .data_write_n   (data_write_n),
        .data_read_n    (data_read_n),
        .data_out       (data_out),
        .data_ready     (data_ready),
        .uo_out         (uo_out),
        .user_interrupt (user_interrupt)
    );

    always #5 clk = ~clk;

    // Run length sampler, mid-cycle so outputs are settled
    always @(negedge clk) begin
        if (uo_out[2]) begin
            if (run_len > 0 && uo_out[4] == run_lvl) begin
                run_len++;
            end else begin
                if (run_len > 0) begin
                    obs_lvl.push_back(run_lvl);
                    obs_len.push_back(run_len);
                end
                run_lvl = uo_out[4];
                run_len = 1;
            end
        end else if (run_len > 0) begin
            obs_lvl.push_back(run_lvl);
            obs_len.push_back(run_len);
            run_len = 0;
        end
    end

    task automatic check_level(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_index(input string what, input prog_index_t exp, input prog_index_t act);
        if (exp !== act) begin
            $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp !== act) begin
            $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string what, input bus_word_t exp, input bus_word_t act);
        if (exp !== act) begin
            $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = u_pulse_tx_top.u_sequencer.u_seq_asserts.fails
                     + u_pulse_tx_top.u_regs.u_regs_asserts.fails;
        $display("Checks failed: %0d, assertion failures: %0d, timeouts: %0d",
                 errors, assert_fails, timeouts);
        if (errors == 0 && assert_fails == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // Wait on active (irq_sel 0) or the interrupt line (irq_sel 1)
    task automatic wait_until(input logic irq_sel, input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while ((irq_sel ? user_interrupt : uo_out[2]) !== level && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if ((irq_sel ? user_interrupt : uo_out[2]) !== level) begin
            $display("Timeout in %s: waited %0d cycles for %s", test_name, TIMEOUT, what);
            timeouts++;
            finish_run();
        end
    endtask

    task automatic bus_write(input logic [5:0] addr, input bus_word_t data, input logic [1:0] mode);
        @(posedge clk);
        #1;
        address      = addr;
        data_in      = data;
        data_write_n = mode;
        @(posedge clk);
        #1;
        data_write_n = 2'b11;
    endtask

    task automatic bus_read(output bus_word_t data);
        @(posedge clk);
        #1;
        data_read_n = 2'b10;
        @(negedge clk);
        data = data_out;
        // Reads complete in the same cycle
        check_level("data ready", 1'b1, data_ready);
        @(posedge clk);
        #1;
        data_read_n = 2'b11;
    endtask

    // Symbol length from the code's duration and the prescaler
    function automatic int sym_cycles(input tx_cfg_t c, input symbol_code_t code);
        duration_t d;
        case (code)
            2'd0:    d = c.dur_low_a;
            2'd1:    d = c.dur_low_b;
            2'd2:    d = c.dur_high_a;
            default: d = c.dur_high_b;
        endcase
        return (int'(d) + 1) * (int'(c.prescale) + 1);
    endfunction

    task automatic add_run(input logic lvl, input int len);
        int last;
        last = exp_len.size() - 1;
        if (last >= 0 && exp_lvl[last] == lvl) begin
            exp_len[last] = exp_len[last] + len;
        end else begin
            exp_lvl.push_back(lvl);
            exp_len.push_back(len);
        end
    endtask

    // Walk the program as the sequencer should, one symbol at a time
    task automatic build_runs(input tx_cfg_t c, input bus_word_t w);
        int           idx;
        logic         ph;
        logic         finished;
        symbol_code_t code;
        exp_lvl.delete();
        exp_len.delete();
        exp_loops = 0;
        idx = c.start_idx;
        ph = 1'b0;
        finished = 1'b0;
        while (!finished) begin
            if (c.use_2bpe) begin
                code = w[idx +: 2];
            end else if (w[idx]) begin
                code = ph ? c.high_sym1 : c.high_sym0;
            end else begin
                code = ph ? c.low_sym1 : c.low_sym0;
            end
            add_run(code[1], sym_cycles(c, code));
            // 1bpe reaches the end only after its second phase
            if (idx == c.end_idx && (c.use_2bpe || ph)) begin
                if (exp_loops == c.loop_count) begin
                    finished = 1'b1;
                end else begin
                    exp_loops++;
                    idx = c.loop_idx;
                end
            end else if (c.use_2bpe) begin
                idx += 2;
            end else if (ph) begin
                idx++;
            end
            ph = !ph;
        end
    endtask

    task automatic load_program(input tx_cfg_t c, input bus_word_t w);
        bus_write(WORD0_ADDR, w, WR32);
        bus_write(PROG_ADDR, {c.loop_count, c.loop_idx, c.end_idx, c.start_idx}, WR32);
        bus_write(DUR_ADDR, {c.dur_high_b, c.dur_high_a, c.dur_low_b, c.dur_low_a}, WR32);
        bus_write(PRE_ADDR, {28'h0, c.prescale}, WR32);
        bus_write(CTRL_ADDR, {6'h00, c.high_sym1, c.high_sym0, c.low_sym1, c.low_sym0,
                              c.use_2bpe, 2'b00, c.invert_output, c.idle_level,
                              c.loop_forever, 1'b0, c.irq_en, 8'h00}, WR32);
        build_runs(c, w);
        obs_lvl.delete();
        obs_len.delete();
        run_len = 0;
    endtask

    // Start and wait for the whole program to play out
    task automatic play_program();
        bus_write(CTRL_ADDR, 32'h10, WR8);
        wait_until(1'b0, 1'b1, "active to rise");
        wait_until(1'b0, 1'b0, "active to fall");
        @(posedge clk);
    endtask

    task automatic compare_runs();
        check_count("run count", exp_len.size(), obs_len.size());
        if (exp_len.size() == obs_len.size()) begin
            foreach (exp_len[i]) begin
                check_level("run level", exp_lvl[i], obs_lvl[i]);
                check_count("run length", exp_len[i], obs_len[i]);
            end
        end
    endtask

    task automatic test_readback();
        tx_cfg_t   c;
        bus_word_t rd;
        test_name = "readback";
        bus_read(rd);
        check_word("reset status", '0, rd);
        c = '0;
        c.use_2bpe = 1'b1;
        c.end_idx = 8'd6;
        c.loop_count = 8'd2;
        {c.dur_low_a, c.dur_low_b, c.dur_high_a, c.dur_high_b} = {8'd1, 8'd2, 8'd3, 8'd4};
        load_program(c, 32'h0000_00B4);
        play_program();
        bus_read(rd);
        check_index("program counter", c.end_idx, rd[23:16]);
        check_count("loop counter", int'(c.loop_count) - exp_loops, int'(rd[15:8]));
        check_level("running", 1'b0, rd[4]);
    endtask

    task automatic test_waveform_2bpe();
        tx_cfg_t c;
        test_name = "waveform_2bpe";
        c = '0;
        c.use_2bpe = 1'b1;
        c.idle_level = 1'b1;
        c.end_idx = 8'd14;
        c.prescale = 4'd1;
        // Distinct durations so each code is visible in the run lengths
        {c.dur_low_a, c.dur_low_b, c.dur_high_a, c.dur_high_b} = {8'd3, 8'd5, 8'd2, 8'd7};
        load_program(c, 32'h0000_2D8E);
        play_program();
        compare_runs();
        @(negedge clk);
        check_level("idle output", c.idle_level, uo_out[4]);
        check_level("active after end", 1'b0, uo_out[2]);
        // Pins 3, 1 and 0 carry nothing
        check_level("unused pins", 1'b0, |{uo_out[3], uo_out[1:0]});
    endtask

    task automatic test_loops_1bpe();
        tx_cfg_t   c;
        bus_word_t rd;
        test_name = "loops_1bpe";
        c = '0;
        c.irq_en = 3'b110;
        c.end_idx = 8'd1;
        c.loop_count = 8'd2;
        c.prescale = 4'd2;
        // Each phase of a bit maps to a code of the other level
        {c.low_sym0, c.low_sym1, c.high_sym0, c.high_sym1} = {2'd0, 2'd3, 2'd2, 2'd1};
        {c.dur_low_a, c.dur_low_b, c.dur_high_a, c.dur_high_b} = {8'd4, 8'd6, 8'd3, 8'd5};
        load_program(c, 32'h0000_0002);
        play_program();
        compare_runs();
        bus_read(rd);
        check_level("loop flag", 1'b1, rd[1]);
        check_level("end flag", 1'b1, rd[2]);
        bus_write(CTRL_ADDR, 32'h04, WR8);
        repeat (20) @(posedge clk);
        bus_read(rd);
        check_level("end flag after clear", 1'b0, rd[2]);
    endtask

    task automatic test_interrupts();
        tx_cfg_t c;
        test_name = "interrupts";
        bus_write(CTRL_ADDR, 32'h07, WR8);
        c = '0;
        c.use_2bpe = 1'b1;
        c.irq_en = 3'b010;
        c.end_idx = 8'd2;
        c.loop_count = 8'd1;
        c.prescale = 4'd1;
        {c.dur_low_a, c.dur_low_b, c.dur_high_a, c.dur_high_b} = {8'd10, 8'd12, 8'd11, 8'd9};
        load_program(c, 32'h0000_0036);
        @(negedge clk);
        check_level("interrupt before start", 1'b0, user_interrupt);
        bus_write(CTRL_ADDR, 32'h10, WR8);
        wait_until(1'b1, 1'b1, "interrupt on first loop");
        check_level("active at loop", 1'b1, uo_out[2]);
        bus_write(CTRL_ADDR, 32'h02, WR8);
        @(negedge clk);
        check_level("interrupt after clear", 1'b0, user_interrupt);
        wait_until(1'b0, 1'b0, "active to fall");
        @(negedge clk);
        check_level("interrupt after end", 1'b0, user_interrupt);
    endtask

    task automatic test_stop_invert();
        tx_cfg_t   c;
        logic      held;
        bus_word_t rd;
        test_name = "stop_invert";
        c = '0;
        c.use_2bpe = 1'b1;
        c.loop_forever = 1'b1;
        c.invert_output = 1'b1;
        c.end_idx = 8'd2;
        {c.dur_low_a, c.dur_low_b, c.dur_high_a, c.dur_high_b} = {8'd2, 8'd3, 8'd4, 8'd5};
        load_program(c, 32'h0000_001B);
        bus_write(CTRL_ADDR, 32'h10, WR8);
        wait_until(1'b0, 1'b1, "active to rise");
        held = 1'b1;
        repeat (200) begin
            @(negedge clk);
            held = held & uo_out[2];
        end
        check_level("active while looping", 1'b1, held);
        bus_write(CTRL_ADDR, 32'h20, WR8);
        @(negedge clk);
        check_level("active after stop", 1'b0, uo_out[2]);
        for (int i = 4; i < 8; i++) begin
            check_level("inverted idle", ~c.idle_level, uo_out[i]);
        end
        bus_read(rd);
        check_level("running after stop", 1'b0, rd[4]);
    endtask

    initial begin
        rst_n        = 1'b0;
        address      = '0;
        data_in      = '0;
        data_write_n = 2'b11;
        data_read_n  = 2'b11;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_readback();
        test_waveform_2bpe();
        test_loops_1bpe();
        test_interrupts();
        test_stop_invert();
        finish_run();
    end

endmodule

/* test/pulse_tx_asserts.sv */
/*
  Protocol checks bound into the sequencer and the register block.
  Single-cycle event checks assume no symbol shorter than two cycles.
  BUS_SIDE set: the start write check of the register block.
  BUS_SIDE clear: the active check of the sequencer.
*/
module pulse_tx_asserts
    import pulse_tx_pkg::*;
#(
    parameter bit BUS_SIDE = 1'b0
) (
    input logic       clk,
    input logic       rst_n,
    input logic       running,
    input logic       active,
    input logic       start_wr,
    input seq_event_t events
);

    // Number of assertion failures so far
    int fails = 0;

    // Event pulses drop after one cycle
    symbol_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        events.symbol_done |=> !events.symbol_done)
        else begin
            fails++;
            $error("symbol_done held high for more than one cycle");
        end

    loop_taken_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        events.loop_taken |=> !events.loop_taken)
        else begin
            fails++;
            $error("loop_taken held high for more than one cycle");
        end

    program_end_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        events.program_end |=> !events.program_end)
        else begin
            fails++;
            $error("program_end held high for more than one cycle");
        end

    generate
        if (BUS_SIDE) begin : g_bus
            start_sets_running: assert property (@(posedge clk) disable iff (!rst_n)
                start_wr |=> running)
                else begin
                    fails++;
                    $error("running not set the cycle after a start write");
                end
        end else begin : g_seq
            // A cycle without running restarts the fetch delay, so no output plays
            active_needs_running: assert property (@(posedge clk) disable iff (!rst_n)
                !running |=> !active)
                else begin
                    fails++;
                    $error("active high without a fresh start after running was low");
                end
        end
    endgenerate

endmodule

bind pulse_sequencer pulse_tx_asserts #(
    .BUS_SIDE (1'b0)
) u_seq_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .running  (running),
    .active   (active),
    .start_wr (1'b0),
    .events   (events)
);

// Start write without a stop in the same word
bind pulse_tx_regs pulse_tx_asserts #(
    .BUS_SIDE (1'b1)
) u_regs_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .running  (running),
    .active   (1'b0),
    .start_wr (ctrl_wr && data_in[4] && !data_in[5]),
    .events   (events)
);

/* verilog/pulse_tx_top.sv */
/*
  Pulse transmitter peripheral on the simple processor bus.
  Writes: data_write_n 10 is 32 bits, 00 is 8 bits, 11 is idle.
  Reads complete in the same cycle and ignore the address.
  uo_out[2] is active, uo_out[7:4] carry the transmit output.
*/
module pulse_tx_top
    import pulse_tx_pkg::*;
#(
    parameter int LOOP_COUNT_WIDTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [5:0] address,
    input  bus_word_t  data_in,
    input  logic [1:0] data_write_n,
    input  logic [1:0] data_read_n,
    output bus_word_t  data_out,
    output logic       data_ready,
    output logic [7:0] uo_out,
    output logic       user_interrupt
);

    tx_cfg_t     cfg;
    logic        running;
    bus_word_t   rd_word;
    logic        mem_we;
    mem_addr_t   mem_waddr;
    bus_word_t   mem_wdata;
    mem_addr_t   mem_raddr;
    bus_word_t   mem_rdata;
    seq_event_t  events;
    prog_index_t pc;
    loop_count_t loop_count;
    logic        tx_out;
    logic        active;

    pulse_tx_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .address        (address),
        .data_in        (data_in),
        .data_write_n   (data_write_n),
        .events         (events),
        .pc             (pc),
        .loop_count     (loop_count),
        .cfg            (cfg),
        .running        (running),
        .irq_flags      (),
        .user_interrupt (user_interrupt),
        .data_out       (rd_word),
        .mem_we         (mem_we),
        .mem_waddr      (mem_waddr),
        .mem_wdata      (mem_wdata)
    );

    symbol_memory u_memory (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_raddr (mem_raddr),
        .mem_rdata (mem_rdata)
    );

    pulse_sequencer #(
        .LOOP_COUNT_WIDTH (LOOP_COUNT_WIDTH)
    ) u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .running    (running),
        .mem_rdata  (mem_rdata),
        .mem_raddr  (mem_raddr),
        .events     (events),
        .pc         (pc),
        .loop_count (loop_count),
        .tx_out     (tx_out),
        .active     (active)
    );

    // Read word only driven while the read strobe is present
    assign data_out   = (data_read_n != 2'b11) ? rd_word : '0;
    assign data_ready = 1'b1;

    assign uo_out = {{4{tx_out}}, 1'b0, active, 2'b00};

endmodule

/* verilog/pulse_tx_regs.sv */
/*
  Bus register file of the pulse transmitter.
  8-bit writes reach only control bits 7:0 (flag clear, start, stop).
  Config and program writes need a 32-bit access.
  Start while running does not restart; stop wins over start.
  Program-word writes are only decoded here, the memory registers them.
*/
module pulse_tx_regs
    import pulse_tx_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [5:0]  address,
    input  bus_word_t   data_in,
    input  logic [1:0]  data_write_n,
    input  seq_event_t  events,
    input  prog_index_t pc,
    input  loop_count_t loop_count,
    output tx_cfg_t     cfg,
    output logic        running,
    output irq_vec_t    irq_flags,
    output logic        user_interrupt,
    output bus_word_t   data_out,
    output logic        mem_we,
    output mem_addr_t   mem_waddr,
    output bus_word_t   mem_wdata
);

    logic     wr_word;
    logic     wr_any;
    logic     reg_sel;
    logic     ctrl_wr;
    irq_vec_t flag_clr;
    irq_vec_t flag_set;

    assign wr_word = (data_write_n == 2'b10);
    assign wr_any  = wr_word || (data_write_n == 2'b00);
    // Address bit 5 low selects the register bank
    assign reg_sel = !address[5];
    assign ctrl_wr = wr_any && reg_sel && (address[4:2] == REG_CTRL);

    // Write one to clear, bit 3 has no flag behind it
    assign flag_clr = ctrl_wr ? data_in[2:0] : '0;
    assign flag_set = irq_vec_t'(events) & cfg.irq_en;

    // Configuration registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (wr_word && reg_sel) begin
            case (address[4:2])
                REG_CTRL: begin
                    cfg.irq_en        <= data_in[10:8];
                    cfg.loop_forever  <= data_in[12];
                    cfg.idle_level    <= data_in[13];
                    cfg.invert_output <= data_in[14];
                    cfg.use_2bpe      <= data_in[17];
                    cfg.low_sym0      <= data_in[19:18];
                    cfg.low_sym1      <= data_in[21:20];
                    cfg.high_sym0     <= data_in[23:22];
                    cfg.high_sym1     <= data_in[25:24];
                end
                REG_PROG:
                    {cfg.loop_count, cfg.loop_idx, cfg.end_idx, cfg.start_idx} <= data_in;
                REG_DUR:
                    {cfg.dur_high_b, cfg.dur_high_a, cfg.dur_low_b, cfg.dur_low_a} <= data_in;
                REG_PRESCALE:
                    cfg.prescale <= data_in[3:0];
                default: begin
                end
            endcase
        end
    end

    // Run state and sticky flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running   <= 1'b0;
            irq_flags <= '0;
        end else begin
            irq_flags <= (irq_flags & ~flag_clr) | flag_set;
            if (ctrl_wr && data_in[CTRL_STOP_BIT]) begin
                running <= 1'b0;
            end else if (ctrl_wr && data_in[CTRL_START_BIT]) begin
                running <= 1'b1;
            end else if (events.program_end) begin
                running <= 1'b0;
            end
        end
    end

    assign user_interrupt = |irq_flags;

    // Program words go straight to the memory capture stage
    assign mem_we    = wr_word && address[5];
    assign mem_waddr = address[2 +: MEM_ADDR_WIDTH];
    assign mem_wdata = data_in;

    // Status word, same for every address
    assign data_out = {8'h00, pc, loop_count, 3'b000, running, 1'b0, irq_flags};

endmodule

/* verilog/symbol_memory.sv */
/*
  Eight-word program store.
  A write is captured on the bus write edge and stored one edge later,
  so the word reads back two cycles after the write.
  Read is asynchronous; contents are undefined until written.
*/
module symbol_memory
    import pulse_tx_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      mem_we,
    input  mem_addr_t mem_waddr,
    input  bus_word_t mem_wdata,
    input  mem_addr_t mem_raddr,
    output bus_word_t mem_rdata
);

    logic      we_q;
    mem_addr_t waddr_q;
    bus_word_t wdata_q;
    bus_word_t words [NUM_PROG_WORDS];

    // Capture stage strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= mem_we;
        end
    end

    // Capture stage payload
    always_ff @(posedge clk) begin
        if (mem_we) begin
            waddr_q <= mem_waddr;
            wdata_q <= mem_wdata;
        end
    end

    // Store stage
    always_ff @(posedge clk) begin
        if (we_q) begin
            words[waddr_q] <= wdata_q;
        end
    end

    assign mem_rdata = words[mem_raddr];

endmodule

/* sequencer/pulse_sequencer.sv */
/*
  Walks the program between start and end index and plays each symbol.
  Counters reload in the first running cycle, so the final program
  counter and loop counter stay readable after the program ends.
  Two more fetch cycles follow, then active rises.
  2bpe mode expects even indices; an odd end index is never reached.
*/
module pulse_sequencer
    import pulse_tx_pkg::*;
#(
    parameter int LOOP_COUNT_WIDTH = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  tx_cfg_t     cfg,
    input  logic        running,
    input  bus_word_t   mem_rdata,
    output mem_addr_t   mem_raddr,
    output seq_event_t  events,
    output prog_index_t pc,
    output loop_count_t loop_count,
    output logic        tx_out,
    output logic        active
);

    logic [1:0]                  start_cnt;
    logic                        phase;
    logic                        eop;
    logic                        level_q;
    logic [LOOP_COUNT_WIDTH-1:0] loop_cnt;
    symbol_t                     symbol;
    logic                        first_load;
    logic                        request;
    logic                        done;
    logic                        step;
    logic                        at_end;
    logic                        do_loop;

    // Start delay, 0 reloads, 1 and 2 fetch, 3 plays
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_cnt <= 2'd0;
        end else if (!running) begin
            start_cnt <= 2'd0;
        end else if (start_cnt != 2'd3) begin
            start_cnt <= start_cnt + 2'd1;
        end
    end

    assign first_load = running && (start_cnt == 2'd2);
    assign active     = running && (start_cnt == 2'd3);

    // No more steps once the last symbol is loaded
    assign step = request && !eop;
    // End index counts only after both phases in 1bpe mode
    assign at_end  = (pc == cfg.end_idx) && (cfg.use_2bpe || phase);
    assign do_loop = cfg.loop_forever || (loop_cnt != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= '0;
            phase    <= 1'b0;
            loop_cnt <= '0;
            eop      <= 1'b0;
        end else if (running && (start_cnt == 2'd0)) begin
            pc       <= cfg.start_idx;
            phase    <= 1'b0;
            loop_cnt <= LOOP_COUNT_WIDTH'(cfg.loop_count);
            eop      <= 1'b0;
        end else if (step) begin
            // Phase is ignored by the decoder in 2bpe mode
            phase <= !phase;
            if (at_end) begin
                if (do_loop) begin
                    pc <= cfg.loop_idx;
                    // Forever mode leaves the count alone
                    if (!cfg.loop_forever) begin
                        loop_cnt <= loop_cnt - 1'b1;
                    end
                end else begin
                    eop <= 1'b1;
                end
            end else if (cfg.use_2bpe) begin
                pc <= pc + 8'd2;
            end else if (phase) begin
                pc <= pc + 8'd1;
            end
        end
    end

    // Level of the symbol entering the timer
    always_ff @(posedge clk) begin
        if (step) begin
            level_q <= symbol.level;
        end
    end

    symbol_decoder u_decoder (
        .cfg       (cfg),
        .pc        (pc),
        .phase     (phase),
        .mem_rdata (mem_rdata),
        .symbol    (symbol)
    );

    symbol_timer u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (active),
        .load    (first_load),
        .symbol  (symbol),
        .request (request),
        .done    (done)
    );

    assign mem_raddr  = pc[5 +: MEM_ADDR_WIDTH];
    assign loop_count = loop_count_t'(loop_cnt);

    // Program end lands in the last cycle of the last symbol
    assign events.symbol_done = done;
    assign events.loop_taken  = step && at_end && do_loop;
    assign events.program_end = done && eop;

    // Idle level outside a program, inversion on both
    assign tx_out = (active ? level_q : cfg.idle_level) ^ cfg.invert_output;

endmodule

/* sequencer/symbol_timer.sv */
/*
  Prescaled countdown for one symbol.
  A symbol lasts (duration+1)*(prescale+1) enabled cycles.
  load starts the first symbol; each expiry reloads from the next one,
  so request pulses on both and done only on expiry.
*/
module symbol_timer
    import pulse_tx_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,
    input  logic    load,
    input  symbol_t symbol,
    output logic    request,
    output logic    done
);

    prescale_t pre_cnt;
    prescale_t pre_reload;
    duration_t dur_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre_cnt    <= '0;
            pre_reload <= '0;
            dur_cnt    <= '0;
        end else if (request) begin
            pre_cnt    <= symbol.prescale;
            pre_reload <= symbol.prescale;
            dur_cnt    <= symbol.duration;
        end else if (enable) begin
            // One duration tick per prescaler wrap
            if (pre_cnt == '0) begin
                pre_cnt <= pre_reload;
                dur_cnt <= dur_cnt - 1'b1;
            end else begin
                pre_cnt <= pre_cnt - 1'b1;
            end
        end
    end

    assign done    = enable && (pre_cnt == '0) && (dur_cnt == '0);
    assign request = load || done;

endmodule

/* sequencer/symbol_decoder.sv */
/*
  Turns the element at the program counter into a timed symbol.
  pc bits 4:1 pick the bit pair inside the fetched word.
  In 1bpe mode pc bit 0 picks one bit of that pair, which is expanded
  into two codes through the symbol maps, one per phase.
*/
module symbol_decoder
    import pulse_tx_pkg::*;
(
    input  tx_cfg_t     cfg,
    input  prog_index_t pc,
    input  logic        phase,
    input  bus_word_t   mem_rdata,
    output symbol_t     symbol
);

    symbol_code_t pair;
    logic         bit_val;
    symbol_code_t code;

    always_comb begin
        pair    = mem_rdata[{pc[4:1], 1'b0} +: 2];
        bit_val = pair[pc[0]];

        if (cfg.use_2bpe) begin
            code = pair;
        end else if (bit_val) begin
            code = phase ? cfg.high_sym1 : cfg.high_sym0;
        end else begin
            code = phase ? cfg.low_sym1 : cfg.low_sym0;
        end

        symbol.level    = code[1];
        symbol.prescale = cfg.prescale;
        // Level and a/b select pick one of four durations
        case (code)
            2'd0:    symbol.duration = cfg.dur_low_a;
            2'd1:    symbol.duration = cfg.dur_low_b;
            2'd2:    symbol.duration = cfg.dur_high_a;
            default: symbol.duration = cfg.dur_high_b;
        endcase
    end

endmodule

/* common/pulse_tx_pkg.sv */
/*
  Shared types for the pulse transmitter peripheral.
  Register map: word offsets 0..3 with address bit 5 clear are the
  configuration registers; address bit 5 set selects program words.
  NUM_PROG_WORDS must stay a power of two so the program index wraps.
  The prescaler sits in bits 3:0 of the prescale register.
*/
package pulse_tx_pkg;

    // Loop counter width, also the default of the module parameters
    localparam int LOOP_COUNT_WIDTH = 8;

    // Program store geometry
    localparam int NUM_PROG_WORDS = 8;
    localparam int MEM_ADDR_WIDTH = $clog2(NUM_PROG_WORDS);

    typedef logic [7:0]                  prog_index_t;
    typedef logic [LOOP_COUNT_WIDTH-1:0] loop_count_t;
    typedef logic [7:0]                  duration_t;
    typedef logic [3:0]                  prescale_t;
    // Bit 1 is the level, bit 0 picks duration a or b
    typedef logic [1:0]                  symbol_code_t;
    // Bit 0 symbol done, bit 1 loop taken, bit 2 program end
    typedef logic [2:0]                  irq_vec_t;
    typedef logic [31:0]                 bus_word_t;
    typedef logic [MEM_ADDR_WIDTH-1:0]   mem_addr_t;

    // Word offsets, compared against address bits 4:2
    localparam logic [2:0] REG_CTRL     = 3'd0;
    localparam logic [2:0] REG_PROG     = 3'd1;
    localparam logic [2:0] REG_DUR      = 3'd2;
    localparam logic [2:0] REG_PRESCALE = 3'd3;

    // Control register command bits
    localparam int CTRL_START_BIT = 4;
    localparam int CTRL_STOP_BIT  = 5;

    // Configuration as seen by the sequencer
    typedef struct packed {
        irq_vec_t     irq_en;
        logic         loop_forever;
        logic         idle_level;
        logic         invert_output;
        logic         use_2bpe;
        // 1bpe symbol maps, per program bit value and phase
        symbol_code_t low_sym0;
        symbol_code_t low_sym1;
        symbol_code_t high_sym0;
        symbol_code_t high_sym1;
        prog_index_t  start_idx;
        prog_index_t  end_idx;
        prog_index_t  loop_idx;
        loop_count_t  loop_count;
        duration_t    dur_low_a;
        duration_t    dur_low_b;
        duration_t    dur_high_a;
        duration_t    dur_high_b;
        prescale_t    prescale;
    } tx_cfg_t;

    // One decoded symbol, ready for the timer
    typedef struct packed {
        logic      level;
        duration_t duration;
        prescale_t prescale;
    } symbol_t;

    // Single-cycle pulses, ordered to line up with irq_vec_t
    typedef struct packed {
        logic program_end;
        logic loop_taken;
        logic symbol_done;
    } seq_event_t;

endpackage
